//--- build.f
+incdir+common
common/dcache_pkg.sv
logic/miss_handler.sv
logic/beat_sequencer.sv
logic/beat_lane.sv
logic/line_merge.sv
logic/dcache_ctrl.sv
bench/dcache_assert.sv
bench/dcache_tb.sv

//--- bench/dcache_tb.sv
// Testbench with clock, reset, stimulus, memory model, reference function and checks
`include "dcache_settings.svh"

module dcache_tb;

	localparam int RANDOM_REQUESTS = 40;
	localparam int TESTS = 4 + RANDOM_REQUESTS;
	localparam int WATCH_CYCLES = TESTS * 200;
	localparam int HIT_LATENCY = 2;

	logic clk;
	logic rst;
	logic req;
	logic req_we;
	logic hit;
	logic modified;
	logic done;
	logic cache_wr;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_ack;
	dcache_pkg::adr_t req_adr;
	dcache_pkg::adr_t victim_adr;
	dcache_pkg::adr_t wb_adr;
	dcache_pkg::line_sel_t req_sel;
	dcache_pkg::line_u req_dat;
	dcache_pkg::line_u line;
	dcache_pkg::line_u victim_dat;
	dcache_pkg::line_u cache_dat;
	dcache_pkg::line_u rd_dat;
	dcache_pkg::beat_sel_t wb_sel;
	dcache_pkg::beat_t wb_wdat;
	dcache_pkg::beat_t wb_rdat;

	dcache_pkg::beat_t mem [0:255];
	logic [32:0] beat_log [$];
	integer seed;
	logic [511:0] exp_cache;
	logic [511:0] exp_rd;
	logic exp_wr;
	int errors;
	int checks;
	int requests;

	dcache_ctrl u_dcache_ctrl (
		.clk_i(clk),
		.rst_i(rst),
		.req_i(req),
		.req_we_i(req_we),
		.req_adr_i(req_adr),
		.req_sel_i(req_sel),
		.req_dat_i(req_dat),
		.hit_i(hit),
		.modified_i(modified),
		.line_i(line),
		.victim_adr_i(victim_adr),
		.victim_dat_i(victim_dat),
		.done_o(done),
		.cache_wr_o(cache_wr),
		.cache_dat_o(cache_dat),
		.rd_dat_o(rd_dat),
		.wb_cyc_o(wb_cyc),
		.wb_stb_o(wb_stb),
		.wb_we_o(wb_we),
		.wb_adr_o(wb_adr),
		.wb_sel_o(wb_sel),
		.wb_dat_o(wb_wdat),
		.wb_dat_i(wb_rdat),
		.wb_ack_i(wb_ack)
	);

	bind dcache_ctrl dcache_assert u_dcache_assert (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cyc_i(wb_cyc_o),
		.stb_i(wb_stb_o),
		.we_i(wb_we_o),
		.adr_i(wb_adr_o),
		.sel_i(wb_sel_o),
		.dat_i(wb_dat_o),
		.ack_i(wb_ack_i),
		.done_i(done_o)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ========================================================================
	// Reference model and helpers
	// ========================================================================

	// Written bytes replace the base line only where the CPU enables them
	function automatic logic [511:0] expected_line(input logic [511:0] base,
		input logic [63:0] sel, input logic [511:0] dat, input logic we);
		logic [511:0] l;
		l = base;
		for (int b = 0; b < `DC_LINE_BYTES; b++) begin
			if (we && sel[b]) begin
				l[8*b +: 8] = dat[8*b +: 8];
			end
		end
		return l;
	endfunction

	function automatic logic [511:0] mem_line(input dcache_pkg::adr_t adr);
		logic [511:0] l;
		for (int k = 0; k < `DC_BEATS; k++) begin
			l[128*k +: 128] = mem[{adr[11:6], 2'(k)}];
		end
		return l;
	endfunction

	function automatic logic [511:0] random_bits();
		logic [511:0] r;
		for (int k = 0; k < 16; k++) begin
			r[32*k +: 32] = $random(seed);
		end
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [511:0] got,
		input logic [511:0] want);
		errors++;
		$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
	endtask

	// ========================================================================
	// Memory model with random ack delay and write-back of store beats
	// ========================================================================

	initial begin : memory_model
		dcache_pkg::adr_t a;
		int delay;
		int idx;
		wb_ack = 1'b0;
		wb_rdat = '0;
		delay = -1;
		for (int i = 0; i < 256; i++) begin
			a = i << 4;
			mem[i] = {a ^ 32'h5a5a_0000, ~a, {4{a[11:4]}}, a + 32'h1357_9bdf};
		end
		forever begin
			@(posedge clk);
			#1;
			if (wb_ack) begin
				wb_ack = 1'b0;
			end else if (wb_cyc && wb_stb) begin
				if (delay < 0) begin
					delay = $random(seed) & 3;
				end
				if (delay == 0) begin
					idx = wb_adr[11:4];
					wb_ack = 1'b1;
					beat_log.push_back({wb_we, wb_adr});
					// Every beat moves a full quarter line
					assert (wb_sel === '1)
						else report_mismatch("wb_sel_o", wb_sel, 16'hffff);
					if (wb_we) begin
						mem[idx] = wb_wdat;
					end else begin
						wb_rdat = mem[idx];
					end
				end
				delay = delay - 1;
			end
		end
	end

	// ========================================================================
	// Stimulus and comparison
	// ========================================================================

	task automatic issue_request(input logic we, input logic is_hit, input logic dirty);
		logic [511:0] base;
		logic [511:0] r;
		logic [31:0] rnd;
		logic [32:0] want;
		int first;
		int waits;
		int nbeats;
		rnd = $random(seed);
		req_adr = {20'h0, rnd[11:0]};
		// Victim sits on another line, 1 to 32 lines away
		victim_adr = {20'h0, req_adr[11:6] + 6'd1 + {1'b0, rnd[16:12]}, 6'h0};
		r = random_bits();
		req_sel = r[63:0];
		req_dat = random_bits();
		line = random_bits();
		victim_dat = random_bits();
		req_we = we;
		hit = is_hit;
		modified = dirty;
		base = is_hit ? line : mem_line(req_adr);
		exp_rd = base;
		exp_cache = expected_line(base, req_sel, req_dat, we);
		exp_wr = we || !is_hit;
		first = beat_log.size();
		requests++;
		req = 1'b1;
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
		end while (!done);
		if (is_hit) begin
			assert (waits - 1 == HIT_LATENCY)
				else report_mismatch("done_o latency", waits - 1, HIT_LATENCY);
		end
		nbeats = is_hit ? 0 : (dirty ? 2 * `DC_BEATS : `DC_BEATS);
		assert (beat_log.size() - first == nbeats)
			else report_mismatch("bus beat count", beat_log.size() - first, nbeats);
		// Victim stores in ascending order come first, then the ascending fill loads
		for (int k = 0; k < nbeats; k++) begin
			if (dirty && k < `DC_BEATS) begin
				want = {1'b1, victim_adr[31:6], 2'(k), 4'h0};
			end else begin
				want = {1'b0, req_adr[31:6], 2'(k % `DC_BEATS), 4'h0};
			end
			assert (beat_log[first + k] === want)
				else report_mismatch("wb_we_o/wb_adr_o", beat_log[first + k], want);
		end
		if (!is_hit && dirty) begin
			assert (mem_line(victim_adr) === victim_dat)
				else report_mismatch("memory at victim_adr_i", mem_line(victim_adr), victim_dat);
		end
		@(posedge clk);
		#1;
		req = 1'b0;
	endtask

	always @(negedge clk) begin
		if (!rst && done) begin
			checks++;
			assert (cache_wr === exp_wr) else report_mismatch("cache_wr_o", cache_wr, exp_wr);
			assert (rd_dat === exp_rd) else report_mismatch("rd_dat_o", rd_dat, exp_rd);
			if (exp_wr) begin
				assert (cache_dat === exp_cache)
					else report_mismatch("cache_dat_o", cache_dat, exp_cache);
			end
		end else if (!rst) begin
			assert (cache_wr !== 1'b1) else report_mismatch("cache_wr_o", cache_wr, 0);
		end
	end

	initial begin : watchdog
		#((16 + WATCH_CYCLES) * 8);
		$display("Watchdog expired: requests still running after %0d cycles", WATCH_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main
		logic [31:0] kind;
		int assert_fails;
		seed = 32'he42d_4bad;
		errors = 0;
		checks = 0;
		requests = 0;
		rst = 1'b1;
		req = 1'b0;
		req_we = 1'b0;
		hit = 1'b0;
		modified = 1'b0;
		req_adr = '0;
		victim_adr = '0;
		req_sel = '0;
		req_dat = '0;
		line = '0;
		victim_dat = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		assert ({done, cache_wr, wb_cyc, wb_stb, wb_we} === 5'b0)
			else report_mismatch("done_o/cache_wr_o/wb_cyc_o/wb_stb_o/wb_we_o",
				{done, cache_wr, wb_cyc, wb_stb, wb_we}, 0);
		@(posedge clk);
		#1;
		// Hit read, hit write, clean miss read, dirty miss write
		issue_request(1'b0, 1'b1, 1'b0);
		issue_request(1'b1, 1'b1, 1'b0);
		issue_request(1'b0, 1'b0, 1'b0);
		issue_request(1'b1, 1'b0, 1'b1);
		for (int n = 0; n < RANDOM_REQUESTS; n++) begin
			kind = $random(seed);
			issue_request(kind[0], kind[1], kind[2]);
		end
		repeat (4) @(posedge clk);
		assert_fails = u_dcache_ctrl.u_dcache_assert.failures;
		$display("Requests %0d, reply checks %0d, errors %0d, assertion failures %0d",
			requests, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0 && checks == TESTS) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- bench/dcache_assert.sv
// Wishbone master and reply protocol assertions for the miss controller top level
module dcache_assert (
	input logic clk_i,
	input logic rst_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input dcache_pkg::adr_t adr_i,
	input dcache_pkg::beat_sel_t sel_i,
	input dcache_pkg::beat_t dat_i,
	input logic ack_i,
	input logic done_i
);

	// Count of failed assertions
	int failures = 0;

	// Cyc and stb both drop for one cycle after every acknowledged beat
	beat_gap: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_i && ack_i |=> !cyc_i && !stb_i)
		else begin
			$error("wb_cyc_o or wb_stb_o stayed high in the cycle after ack");
			failures++;
		end

	// A beat waiting for ack keeps every master output frozen
	beat_held: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_i && !ack_i |=> cyc_i && stb_i && $stable(we_i) && $stable(adr_i) &&
		$stable(sel_i) && $stable(dat_i))
		else begin
			$error("Master outputs changed while a beat waited for ack");
			failures++;
		end

	done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
		else begin
			$error("done_o stayed high for more than one cycle");
			failures++;
		end

	// The reply only comes once the memory bus is quiet
	done_idle_bus: assert property (@(posedge clk_i) disable iff (rst_i) !(done_i && cyc_i))
		else begin
			$error("done_o is high while a bus cycle is open");
			failures++;
		end

endmodule

//--- logic/dcache_ctrl.sv
// Miss controller top level: miss handler, beat sequencer, fill lanes and line merge
`include "dcache_settings.svh"

module dcache_ctrl (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	input logic req_we_i,
	input dcache_pkg::adr_t req_adr_i,
	input dcache_pkg::line_sel_t req_sel_i,
	input dcache_pkg::line_u req_dat_i,
	input logic hit_i,
	input logic modified_i,
	input dcache_pkg::line_u line_i,
	input dcache_pkg::adr_t victim_adr_i,
	input dcache_pkg::line_u victim_dat_i,
	output logic done_o,
	output logic cache_wr_o,
	output dcache_pkg::line_u cache_dat_o,
	output dcache_pkg::line_u rd_dat_o,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output dcache_pkg::adr_t wb_adr_o,
	output dcache_pkg::beat_sel_t wb_sel_o,
	output dcache_pkg::beat_t wb_dat_o,
	input dcache_pkg::beat_t wb_dat_i,
	input logic wb_ack_i
);

	logic seq_start;
	logic seq_store;
	dcache_pkg::adr_t seq_adr;
	logic line_done;
	logic commit;
	logic line_ready;
	logic lane_clear;
	logic [`DC_BEATS-1:0] lane_ld;
	wire [`DC_BEATS-1:0] lane_valid;
	// Each lane drives its own quarter of the assembled line
	wire dcache_pkg::line_u lane_dat;

	miss_handler u_miss_handler (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(req_i),
		.hit_i(hit_i),
		.modified_i(modified_i),
		.req_adr_i(req_adr_i),
		.victim_adr_i(victim_adr_i),
		.line_done_i(line_done),
		.line_ready_i(line_ready),
		.seq_start_o(seq_start),
		.seq_store_o(seq_store),
		.seq_adr_o(seq_adr),
		.commit_o(commit),
		.done_o(done_o)
	);

	// The victim line goes straight from the cache array to the bus
	beat_sequencer u_beat_sequencer (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.start_i(seq_start),
		.store_i(seq_store),
		.line_adr_i(seq_adr),
		.store_line_i(victim_dat_i),
		.line_done_o(line_done),
		.lane_clear_o(lane_clear),
		.lane_ld_o(lane_ld),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_sel_o(wb_sel_o),
		.wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i)
	);

	for (genvar g = 0; g < `DC_BEATS; g++) begin : g_lane
		beat_lane u_beat_lane (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.clear_i(lane_clear),
			.ld_i(lane_ld[g]),
			.dat_i(wb_dat_i),
			.dat_o(lane_dat.beat[g]),
			.valid_o(lane_valid[g])
		);
	end

	line_merge u_line_merge (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.commit_i(commit),
		.req_we_i(req_we_i),
		.req_sel_i(req_sel_i),
		.req_dat_i(req_dat_i),
		.line_i(line_i),
		.lane_dat_i(lane_dat),
		.lane_valid_i(lane_valid),
		.line_ready_o(line_ready),
		.cache_wr_o(cache_wr_o),
		.cache_dat_o(cache_dat_o),
		.rd_dat_o(rd_dat_o)
	);

endmodule

//--- logic/line_merge.sv
// Line assembly and CPU byte merge with the registered cache write and read data
`include "dcache_settings.svh"

module line_merge (
	input logic clk_i,
	input logic rst_i,
	input logic commit_i,
	input logic req_we_i,
	input dcache_pkg::line_sel_t req_sel_i,
	input dcache_pkg::line_u req_dat_i,
	input dcache_pkg::line_u line_i,
	input dcache_pkg::line_u lane_dat_i,
	input logic [`DC_BEATS-1:0] lane_valid_i,
	output logic line_ready_o,
	output logic cache_wr_o,
	output dcache_pkg::line_u cache_dat_o,
	output dcache_pkg::line_u rd_dat_o
);

	logic use_lanes;
	dcache_pkg::line_u base;
	dcache_pkg::line_u merged;

	// ========================================================================
	// Base line selection and byte merge
	// ========================================================================

	// A complete set of lanes means a fill, otherwise the line came from the array
	assign use_lanes = &lane_valid_i;
	assign line_ready_o = use_lanes;
	assign base = use_lanes ? lane_dat_i : line_i;

	always_comb begin
		merged = base;
		if (req_we_i) begin
			for (int b = 0; b < `DC_LINE_BYTES; b++) begin
				if (req_sel_i[b]) begin
					merged.bytes[b] = req_dat_i.bytes[b];
				end
			end
		end
	end

	// ========================================================================
	// Commit registers
	// ========================================================================

	// A fill always rewrites the array, a hit only when the CPU writes
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			cache_wr_o <= 1'b0;
		end else begin
			cache_wr_o <= commit_i & (req_we_i | use_lanes);
		end
	end

	always_ff @(posedge clk_i) begin
		if (commit_i) begin
			cache_dat_o <= merged;
			rd_dat_o <= base;
		end
	end

endmodule

//--- logic/beat_lane.sv
// One quarter-line fill slot: beat holding register with its valid flag
module beat_lane (
	input logic clk_i,
	input logic rst_i,
	input logic clear_i,
	input logic ld_i,
	input dcache_pkg::beat_t dat_i,
	output dcache_pkg::beat_t dat_o,
	output logic valid_o
);

	logic valid_q;
	dcache_pkg::beat_t dat_q;

	// Valid marks this quarter of the line as arrived from memory
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (clear_i) begin
			valid_q <= 1'b0;
		end else if (ld_i) begin
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ld_i) begin
			dat_q <= dat_i;
		end
	end

	assign dat_o = dat_q;
	assign valid_o = valid_q;

endmodule

//--- logic/beat_sequencer.sv
// Wishbone classic master moving one cache line as four store or load beats
`include "dcache_settings.svh"

module beat_sequencer (
	input logic clk_i,
	input logic rst_i,
	input logic start_i,
	input logic store_i,
	input dcache_pkg::adr_t line_adr_i,
	input dcache_pkg::line_u store_line_i,
	output logic line_done_o,
	output logic lane_clear_o,
	output logic [`DC_BEATS-1:0] lane_ld_o,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output dcache_pkg::adr_t wb_adr_o,
	output dcache_pkg::beat_sel_t wb_sel_o,
	output dcache_pkg::beat_t wb_dat_o,
	input dcache_pkg::beat_t wb_dat_i,
	input logic wb_ack_i
);

	logic busy_q;
	logic cyc_q;
	logic we_q;
	logic [`DC_OFFSET_BITS-`DC_BEAT_LSB-1:0] cnt_q;
	logic [`DC_ADR_W-1:`DC_OFFSET_BITS] tag_q;
	logic [1:0] drain_q;

	// ========================================================================
	// Beat control
	// ========================================================================

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			cyc_q <= 1'b0;
			we_q <= 1'b0;
			cnt_q <= '0;
			line_done_o <= 1'b0;
			drain_q <= '0;
		end else begin
			line_done_o <= 1'b0;
			// A finished fill ages here until the merge has taken it
			drain_q <= {drain_q[0], line_done_o & ~we_q};
			if (!busy_q) begin
				if (start_i) begin
					busy_q <= 1'b1;
					cyc_q <= 1'b1;
					we_q <= store_i;
					cnt_q <= '0;
				end
			end else if (cyc_q) begin
				if (wb_ack_i) begin
					// Drop cyc and stb for one cycle between beats
					cyc_q <= 1'b0;
					if (cnt_q == `DC_BEATS-1) begin
						busy_q <= 1'b0;
						line_done_o <= 1'b1;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
			end else begin
				cyc_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!busy_q && start_i) begin
			tag_q <= line_adr_i[`DC_ADR_W-1:`DC_OFFSET_BITS];
		end
	end

	// ========================================================================
	// Bus outputs and lane strobes
	// ========================================================================

	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = cyc_q;
	assign wb_we_o = cyc_q & we_q;
	assign wb_adr_o = {tag_q, cnt_q, {`DC_BEAT_LSB{1'b0}}};
	assign wb_sel_o = '1;
	// The victim line is held stable by the cache array for the whole request
	assign wb_dat_o = store_line_i.beat[cnt_q];

	always_comb begin
		lane_ld_o = '0;
		if (cyc_q && !we_q && wb_ack_i) begin
			lane_ld_o[cnt_q] = 1'b1;
		end
	end

	// Lanes empty at the start of a load and once the filled line has been merged
	assign lane_clear_o = (start_i & ~store_i) | drain_q[1];

endmodule

//--- logic/miss_handler.sv
// Request FSM of the miss controller: hit, victim dump, line fill, commit and reply
module miss_handler (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	input logic hit_i,
	input logic modified_i,
	input dcache_pkg::adr_t req_adr_i,
	input dcache_pkg::adr_t victim_adr_i,
	input logic line_done_i,
	input logic line_ready_i,
	output logic seq_start_o,
	output logic seq_store_o,
	output dcache_pkg::adr_t seq_adr_o,
	output logic commit_o,
	output logic done_o
);

	dcache_pkg::phase_e phase_q;

	// ========================================================================
	// Phase register
	// ========================================================================

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			phase_q <= dcache_pkg::IDLE;
			seq_start_o <= 1'b0;
			seq_store_o <= 1'b0;
		end else begin
			seq_start_o <= 1'b0;
			case (phase_q)
				dcache_pkg::IDLE: begin
					if (req_i) begin
						if (hit_i) begin
							phase_q <= dcache_pkg::COMMIT;
						end else if (modified_i) begin
							// The dirty victim has to leave before the fill
							phase_q <= dcache_pkg::DUMP;
							seq_start_o <= 1'b1;
							seq_store_o <= 1'b1;
						end else begin
							phase_q <= dcache_pkg::FILL;
							seq_start_o <= 1'b1;
							seq_store_o <= 1'b0;
						end
					end
				end
				dcache_pkg::DUMP: begin
					if (line_done_i) begin
						phase_q <= dcache_pkg::FILL;
						seq_start_o <= 1'b1;
						seq_store_o <= 1'b0;
					end
				end
				dcache_pkg::FILL: begin
					if (line_ready_i) begin
						phase_q <= dcache_pkg::COMMIT;
					end
				end
				dcache_pkg::COMMIT: begin
					phase_q <= dcache_pkg::REPLY;
				end
				default: begin
					phase_q <= dcache_pkg::IDLE;
				end
			endcase
		end
	end

	// Line address handed to the sequencer along with the start pulse
	always_ff @(posedge clk_i) begin
		if (phase_q == dcache_pkg::IDLE && req_i && !hit_i && modified_i) begin
			seq_adr_o <= victim_adr_i;
		end else if ((phase_q == dcache_pkg::IDLE && req_i && !hit_i) ||
			(phase_q == dcache_pkg::DUMP && line_done_i)) begin
			seq_adr_o <= req_adr_i;
		end
	end

	// Merge results are registered during COMMIT and become visible in REPLY
	assign commit_o = (phase_q == dcache_pkg::COMMIT);
	assign done_o = (phase_q == dcache_pkg::REPLY);

endmodule

//--- common/dcache_pkg.sv
// Shared types: address, beat, byte selects, the line union and the miss handler phase
`include "dcache_settings.svh"

package dcache_pkg;

	// ========================================================================
	// Bus and address words
	// ========================================================================

	// Byte address
	typedef logic [`DC_ADR_W-1:0] adr_t;

	// One 128-bit bus beat
	typedef logic [`DC_BEAT_BYTES*8-1:0] beat_t;

	// Wishbone byte select for one beat
	typedef logic [`DC_BEAT_BYTES-1:0] beat_sel_t;

	// CPU byte enables across a whole line
	typedef logic [`DC_LINE_BYTES-1:0] line_sel_t;

	// ========================================================================
	// Cache line
	// ========================================================================

	// The byte view serves the byte-enable merge, the beat view serves
	// the bus transfers in both directions
	typedef union packed {
		logic [`DC_LINE_BYTES-1:0][7:0] bytes;
		beat_t [`DC_BEATS-1:0] beat;
	} line_u;

	// Miss handler phases
	typedef enum logic [2:0] {
		IDLE,
		DUMP,
		FILL,
		COMMIT,
		REPLY
	} phase_e;

endpackage

//--- common/dcache_settings.svh
// Geometry macros for the data-cache miss controller: address, line, beat and byte sizes
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ============================================================================
// Address geometry
// ============================================================================

// Byte address width on both the CPU and the memory side
`define DC_ADR_W 32

// ============================================================================
// Line and beat geometry
// ============================================================================

// One Wishbone beat carries a quarter line
`define DC_BEAT_BYTES 16

// Beats per cache line, always sent in ascending order
`define DC_BEATS 4

// Cache line size in bytes
`define DC_LINE_BYTES 64

// Address bits below the line tag
`define DC_OFFSET_BITS 6

// The beat index sits just above the byte offset inside a beat
`define DC_BEAT_LSB 4

`endif
